//--- src/mipsCore_defs.svh
`ifndef MIPS_CORE_DEFS_SVH
`define MIPS_CORE_DEFS_SVH

// Program counter value out of reset
`define MIPS_BOOT_ADDR 32'h0000_0000

// Data and address width
`define MIPS_XLEN 32

// Register number width
`define MIPS_REG_BITS 5

`endif

//--- src/mipsCorePkg.sv
`default_nettype none

`include "mipsCore_defs.svh"

package mipsCorePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbLink,
        wbMem
    } wbSource_t;

    typedef struct packed {
        aluOp_t                    aluOp;
        logic                      useImmediate;
        logic                      zeroExtendImm;
        logic [`MIPS_XLEN-1:0]     immediate;
        logic [`MIPS_REG_BITS-1:0] readReg1;
        logic [`MIPS_REG_BITS-1:0] readReg2;
        logic [`MIPS_REG_BITS-1:0] destReg;
        wbSource_t                 wbSource;
        logic                      memLoad;
        logic                      memStore;
        logic                      isBranch;
        logic                      branchOnEqual;
        logic                      isJump;
        logic                      jumpRegister;
        logic [25:0]               jumpIndex;
    } ctrlBundle_t;

    // Reads nothing, writes nothing
    localparam ctrlBundle_t nopBundle = '{
        aluOp: aluAdd,
        wbSource: wbNone,
        default: '0
    };

endpackage

`default_nettype wire

//--- src/registerFile.sv
`default_nettype none

`include "mipsCore_defs.svh"

module registerFile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`MIPS_REG_BITS-1:0] readAddr1,
    input  logic [`MIPS_REG_BITS-1:0] readAddr2,
    output logic [`MIPS_XLEN-1:0]     readData1,
    output logic [`MIPS_XLEN-1:0]     readData2,
    input  logic                      writeEnable,
    input  logic [`MIPS_REG_BITS-1:0] writeAddr,
    input  logic [`MIPS_XLEN-1:0]     writeData
);

    logic [`MIPS_XLEN-1:0] regs [32];
    logic                  writeActive;

    assign writeActive = writeEnable && !reset && writeAddr != '0;

    always_ff @(posedge clk) begin
        if (writeActive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is visible to the reader
    assign readData1 = (readAddr1 == '0) ? '0 :
                       (writeActive && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 :
                       (writeActive && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

//--- src/arithmeticLogicUnit.sv
`default_nettype none

`include "mipsCore_defs.svh"

module arithmeticLogicUnit (
    input  mipsCorePkg::aluOp_t   op,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    output logic [`MIPS_XLEN-1:0] result
);

    always_comb begin
        case (op)
            mipsCorePkg::aluAdd: result = a + b;
            mipsCorePkg::aluSub: result = a - b;
            mipsCorePkg::aluAnd: result = a & b;
            mipsCorePkg::aluOr:  result = a | b;
            mipsCorePkg::aluSlt: begin
                result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            mipsCorePkg::aluLui: result = b << 16;
            default:             result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- src/instructionDecoder.sv
`default_nettype none

`include "mipsCore_defs.svh"

module instructionDecoder (
    input  logic [`MIPS_XLEN-1:0]    instruction,
    output mipsCorePkg::ctrlBundle_t controls
);

    logic [5:0]                opcode;
    logic [5:0]                funct;
    logic [`MIPS_REG_BITS-1:0] rs;
    logic [`MIPS_REG_BITS-1:0] rt;
    logic [`MIPS_REG_BITS-1:0] rd;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign rs = instruction[25:21];
    assign rt = instruction[20:16];
    assign rd = instruction[15:11];

    always_comb begin
        controls = mipsCorePkg::nopBundle;
        // Raw 16-bit field, extended in decode
        controls.immediate = {16'b0, instruction[15:0]};
        controls.jumpIndex = instruction[25:0];
        case (opcode)
            6'h00: begin
                controls.readReg1 = rs;
                controls.readReg2 = rt;
                controls.destReg = rd;
                controls.wbSource = mipsCorePkg::wbAlu;
                case (funct)
                    6'h21: controls.aluOp = mipsCorePkg::aluAdd;
                    6'h23: controls.aluOp = mipsCorePkg::aluSub;
                    6'h24: controls.aluOp = mipsCorePkg::aluAnd;
                    6'h25: controls.aluOp = mipsCorePkg::aluOr;
                    6'h2a: controls.aluOp = mipsCorePkg::aluSlt;
                    6'h08: begin
                        controls.readReg2 = '0;
                        controls.destReg = '0;
                        controls.wbSource = mipsCorePkg::wbNone;
                        controls.isJump = 1'b1;
                        controls.jumpRegister = 1'b1;
                    end
                    default: controls = mipsCorePkg::nopBundle;
                endcase
            end
            6'h09, 6'h0d, 6'h0f, 6'h23: begin
                controls.readReg1 = (opcode == 6'h0f) ? '0 : rs;
                controls.destReg = rt;
                controls.useImmediate = 1'b1;
                controls.wbSource = mipsCorePkg::wbAlu;
                if (opcode == 6'h0d) begin
                    controls.zeroExtendImm = 1'b1;
                    controls.aluOp = mipsCorePkg::aluOr;
                end
                if (opcode == 6'h0f) begin
                    controls.zeroExtendImm = 1'b1;
                    controls.aluOp = mipsCorePkg::aluLui;
                end
                if (opcode == 6'h23) begin
                    controls.wbSource = mipsCorePkg::wbMem;
                    controls.memLoad = 1'b1;
                end
            end
            6'h2b: begin
                controls.readReg1 = rs;
                controls.readReg2 = rt;
                controls.useImmediate = 1'b1;
                controls.memStore = 1'b1;
            end
            6'h04, 6'h05: begin
                controls.readReg1 = rs;
                controls.readReg2 = rt;
                controls.isBranch = 1'b1;
                controls.branchOnEqual = (opcode == 6'h04);
            end
            6'h02: controls.isJump = 1'b1;
            default: controls = mipsCorePkg::nopBundle;
        endcase
    end

endmodule

`default_nettype wire

//--- src/fetchUnit.sv
`default_nettype none

`include "mipsCore_defs.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MIPS_XLEN-1:0] instrDatR,
    input  logic                  instrAck,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`MIPS_XLEN-1:0] redirectTarget,
    output logic                  instrCyc,
    output logic                  instrStb,
    output logic [`MIPS_XLEN-1:0] instrAdr,
    output logic [`MIPS_XLEN-1:0] fetchedInstr,
    output logic [`MIPS_XLEN-1:0] fetchedPc,
    output logic                  fetchedValid
);

    logic [`MIPS_XLEN-1:0] pc;
    logic                  fetchEnable;
    logic                  accept;
    logic [`MIPS_XLEN-1:0] nextPc;

    logic                  skidValid;
    logic [`MIPS_XLEN-1:0] skidInstr;
    logic [`MIPS_XLEN-1:0] skidPc;

    logic                  redirectPending;
    logic [`MIPS_XLEN-1:0] pendingTarget;

    // No new access while the skid buffer is full
    assign instrCyc = fetchEnable && !skidValid;
    assign instrStb = instrCyc;
    assign instrAdr = pc;
    assign accept = instrCyc && instrAck;

    assign fetchedValid = skidValid || accept;
    assign fetchedInstr = skidValid ? skidInstr : instrDatR;
    assign fetchedPc = skidValid ? skidPc : pc;

    always_comb begin
        if (redirect) begin
            nextPc = redirectTarget;
        end else if (redirectPending) begin
            nextPc = pendingTarget;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_BOOT_ADDR;
            fetchEnable <= 1'b0;
            skidValid <= 1'b0;
            redirectPending <= 1'b0;
        end else begin
            fetchEnable <= 1'b1;
            if (accept) begin
                pc <= nextPc;
                redirectPending <= 1'b0;
            end else if (redirect && skidValid) begin
                // Delay slot already sits in the skid buffer
                pc <= redirectTarget;
            end else if (redirect) begin
                // Delay slot still in flight
                redirectPending <= 1'b1;
            end
            if (accept && stall) begin
                skidValid <= 1'b1;
            end else if (!stall) begin
                skidValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && stall) begin
            skidInstr <= instrDatR;
            skidPc <= pc;
        end
        if (redirect) begin
            pendingTarget <= redirectTarget;
        end
    end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`default_nettype none

`include "mipsCore_defs.svh"

module decodeStage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`MIPS_XLEN-1:0]     fetchedInstr,
    input  logic [`MIPS_XLEN-1:0]     fetchedPc,
    input  logic                      fetchedValid,
    input  logic                      memBusy,
    input  logic                      exForwardValid,
    input  logic [`MIPS_REG_BITS-1:0] exForwardReg,
    input  logic [`MIPS_XLEN-1:0]     exForwardValue,
    input  logic                      wbWen,
    input  logic [`MIPS_REG_BITS-1:0] wbReg,
    input  logic [`MIPS_XLEN-1:0]     wbData,
    output logic                      stallFetch,
    output logic                      redirect,
    output logic [`MIPS_XLEN-1:0]     redirectTarget,
    output mipsCorePkg::ctrlBundle_t  exCtrl,
    output logic [`MIPS_XLEN-1:0]     exResult,
    output logic [`MIPS_XLEN-1:0]     exStoreData,
    output logic [`MIPS_XLEN-1:0]     exPc,
    output logic                      exValid
);

    logic                     dValid;
    logic [`MIPS_XLEN-1:0]    dInstr;
    logic [`MIPS_XLEN-1:0]    dPc;
    mipsCorePkg::ctrlBundle_t decoded;
    mipsCorePkg::ctrlBundle_t ctrl;
    logic [`MIPS_XLEN-1:0]    rfData1;
    logic [`MIPS_XLEN-1:0]    rfData2;
    logic [`MIPS_XLEN-1:0]    operandA;
    logic [`MIPS_XLEN-1:0]    operandB;
    logic [`MIPS_XLEN-1:0]    immExt;
    logic [`MIPS_XLEN-1:0]    aluResult;
    logic                     loadUse;
    logic                     branchTaken;

    // Memory stage first, then writeback, then the register file
    function automatic logic [`MIPS_XLEN-1:0] forwardOperand(
        input logic [`MIPS_REG_BITS-1:0] regNum,
        input logic [`MIPS_XLEN-1:0]     fileValue
    );
        if (regNum == '0) begin
            return fileValue;
        end
        if (exForwardValid && exForwardReg == regNum) begin
            return exForwardValue;
        end
        if (wbWen && wbReg == regNum) begin
            return wbData;
        end
        return fileValue;
    endfunction

    // A memory-stage destination without a forwardable value is a load
    function automatic logic loadPending(input logic [`MIPS_REG_BITS-1:0] regNum);
        return regNum != '0 && exForwardReg == regNum && !exForwardValid;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!stallFetch) begin
            dValid <= fetchedValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallFetch) begin
            dInstr <= fetchedInstr;
            dPc <= fetchedPc;
        end
    end

    instructionDecoder decoder0 (
        .instruction(dInstr),
        .controls(decoded)
    );

    assign ctrl = dValid ? decoded : mipsCorePkg::nopBundle;

    registerFile regFile0 (
        .clk(clk),
        .reset(reset),
        .readAddr1(ctrl.readReg1),
        .readAddr2(ctrl.readReg2),
        .readData1(rfData1),
        .readData2(rfData2),
        .writeEnable(wbWen),
        .writeAddr(wbReg),
        .writeData(wbData)
    );

    always_comb begin
        operandA = forwardOperand(ctrl.readReg1, rfData1);
        operandB = forwardOperand(ctrl.readReg2, rfData2);
        loadUse = loadPending(ctrl.readReg1) || loadPending(ctrl.readReg2);
    end

    assign stallFetch = loadUse || memBusy;

    assign immExt = ctrl.zeroExtendImm ? {16'b0, ctrl.immediate[15:0]}
                                       : {{16{ctrl.immediate[15]}}, ctrl.immediate[15:0]};

    arithmeticLogicUnit alu0 (
        .op(ctrl.aluOp),
        .a(operandA),
        .b(ctrl.useImmediate ? immExt : operandB),
        .result(aluResult)
    );

    assign branchTaken = ctrl.isBranch && ((operandA == operandB) == ctrl.branchOnEqual);
    assign redirect = !stallFetch && (ctrl.isJump || branchTaken);

    always_comb begin
        if (!ctrl.isJump) begin
            redirectTarget = dPc + 32'd4 + {immExt[29:0], 2'b00};
        end else if (ctrl.jumpRegister) begin
            redirectTarget = operandA;
        end else begin
            redirectTarget = {dPc[31:28], ctrl.jumpIndex, 2'b00};
        end
    end

    // Bubble onward while waiting on a load
    assign exValid = dValid && !loadUse;
    assign exCtrl = loadUse ? mipsCorePkg::nopBundle : ctrl;
    assign exResult = aluResult;
    assign exStoreData = operandB;
    assign exPc = dPc;

endmodule

`default_nettype wire

//--- src/memoryStage.sv
`default_nettype none

`include "mipsCore_defs.svh"

module memoryStage (
    input  logic                      clk,
    input  logic                      reset,
    input  mipsCorePkg::ctrlBundle_t  exCtrl,
    input  logic [`MIPS_XLEN-1:0]     exResult,
    input  logic [`MIPS_XLEN-1:0]     exStoreData,
    input  logic [`MIPS_XLEN-1:0]     exPc,
    input  logic                      exValid,
    input  logic [`MIPS_XLEN-1:0]     dataDatR,
    input  logic                      dataAck,
    output logic                      dataCyc,
    output logic                      dataStb,
    output logic                      dataWe,
    output logic [`MIPS_XLEN-1:0]     dataAdr,
    output logic [`MIPS_XLEN-1:0]     dataDatW,
    output logic                      memBusy,
    output logic                      exForwardValid,
    output logic [`MIPS_REG_BITS-1:0] exForwardReg,
    output logic [`MIPS_XLEN-1:0]     exForwardValue,
    output logic                      wbWen,
    output logic [`MIPS_REG_BITS-1:0] wbReg,
    output logic [`MIPS_XLEN-1:0]     wbData,
    output logic [`MIPS_XLEN-1:0]     debugPc
);

    logic                     mValid;
    mipsCorePkg::ctrlBundle_t mCtrl;
    logic [`MIPS_XLEN-1:0]    mResult;
    logic [`MIPS_XLEN-1:0]    mStoreData;
    logic [`MIPS_XLEN-1:0]    mPc;
    logic                     memAccess;
    logic                     retire;

    always_ff @(posedge clk) begin
        if (reset) begin
            mValid <= 1'b0;
        end else if (!memBusy) begin
            mValid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            mCtrl <= exCtrl;
            mResult <= exResult;
            mStoreData <= exStoreData;
            mPc <= exPc;
        end
    end

    // Address and data held by the register until ack
    assign memAccess = mValid && (mCtrl.memLoad || mCtrl.memStore);
    assign dataCyc = memAccess;
    assign dataStb = memAccess;
    assign dataWe = memAccess && mCtrl.memStore;
    assign dataAdr = mResult;
    assign dataDatW = mStoreData;
    assign memBusy = memAccess && !dataAck;

    assign exForwardReg = mValid ? mCtrl.destReg : '0;
    assign exForwardValid = mValid && !mCtrl.memLoad && mCtrl.destReg != '0;
    assign exForwardValue = mResult;

    assign retire = mValid && !memBusy;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWen <= 1'b0;
        end else begin
            wbWen <= retire && mCtrl.destReg != '0;
        end
    end

    always_ff @(posedge clk) begin
        wbReg <= mCtrl.destReg;
        debugPc <= mPc;
        wbData <= (mCtrl.wbSource == mipsCorePkg::wbMem) ? dataDatR : mResult;
    end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`default_nettype none

`include "mipsCore_defs.svh"

module mipsCore (
    input  logic                      clk,
    input  logic                      reset,

    output logic                      instrCyc,
    output logic                      instrStb,
    output logic [`MIPS_XLEN-1:0]     instrAdr,
    input  logic [`MIPS_XLEN-1:0]     instrDatR,
    input  logic                      instrAck,

    output logic                      dataCyc,
    output logic                      dataStb,
    output logic                      dataWe,
    output logic [`MIPS_XLEN-1:0]     dataAdr,
    output logic [`MIPS_XLEN-1:0]     dataDatW,
    input  logic [`MIPS_XLEN-1:0]     dataDatR,
    input  logic                      dataAck,

    output logic [`MIPS_XLEN-1:0]     debugPc,
    output logic                      debugWen,
    output logic [`MIPS_REG_BITS-1:0] debugWnum,
    output logic [`MIPS_XLEN-1:0]     debugWdata
);

    logic [`MIPS_XLEN-1:0]     fetchedInstr;
    logic [`MIPS_XLEN-1:0]     fetchedPc;
    logic                      fetchedValid;
    logic                      stallFetch;
    logic                      redirect;
    logic [`MIPS_XLEN-1:0]     redirectTarget;

    mipsCorePkg::ctrlBundle_t  exCtrl;
    logic [`MIPS_XLEN-1:0]     exResult;
    logic [`MIPS_XLEN-1:0]     exStoreData;
    logic [`MIPS_XLEN-1:0]     exPc;
    logic                      exValid;

    logic                      memBusy;
    logic                      exForwardValid;
    logic [`MIPS_REG_BITS-1:0] exForwardReg;
    logic [`MIPS_XLEN-1:0]     exForwardValue;
    logic                      wbWen;
    logic [`MIPS_REG_BITS-1:0] wbReg;
    logic [`MIPS_XLEN-1:0]     wbData;

    fetchUnit fetch0 (
        .clk(clk),
        .reset(reset),
        .instrDatR(instrDatR),
        .instrAck(instrAck),
        .stall(stallFetch),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .instrCyc(instrCyc),
        .instrStb(instrStb),
        .instrAdr(instrAdr),
        .fetchedInstr(fetchedInstr),
        .fetchedPc(fetchedPc),
        .fetchedValid(fetchedValid)
    );

    decodeStage decode0 (
        .clk(clk),
        .reset(reset),
        .fetchedInstr(fetchedInstr),
        .fetchedPc(fetchedPc),
        .fetchedValid(fetchedValid),
        .memBusy(memBusy),
        .exForwardValid(exForwardValid),
        .exForwardReg(exForwardReg),
        .exForwardValue(exForwardValue),
        .wbWen(wbWen),
        .wbReg(wbReg),
        .wbData(wbData),
        .stallFetch(stallFetch),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .exCtrl(exCtrl),
        .exResult(exResult),
        .exStoreData(exStoreData),
        .exPc(exPc),
        .exValid(exValid)
    );

    memoryStage memory0 (
        .clk(clk),
        .reset(reset),
        .exCtrl(exCtrl),
        .exResult(exResult),
        .exStoreData(exStoreData),
        .exPc(exPc),
        .exValid(exValid),
        .dataDatR(dataDatR),
        .dataAck(dataAck),
        .dataCyc(dataCyc),
        .dataStb(dataStb),
        .dataWe(dataWe),
        .dataAdr(dataAdr),
        .dataDatW(dataDatW),
        .memBusy(memBusy),
        .exForwardValid(exForwardValid),
        .exForwardReg(exForwardReg),
        .exForwardValue(exForwardValue),
        .wbWen(wbWen),
        .wbReg(wbReg),
        .wbData(wbData),
        .debugPc(debugPc)
    );

    assign debugWen = wbWen;
    assign debugWnum = wbReg;
    assign debugWdata = wbData;

endmodule

`default_nettype wire

//--- tests/mipsCore_assertions.sv
`default_nettype none

`include "mipsCore_defs.svh"

module mipsCoreAssertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      instrCyc,
    input logic                      instrStb,
    input logic [`MIPS_XLEN-1:0]     instrAdr,
    input logic                      instrAck,
    input logic                      dataCyc,
    input logic                      dataStb,
    input logic                      dataWe,
    input logic [`MIPS_XLEN-1:0]     dataAdr,
    input logic [`MIPS_XLEN-1:0]     dataDatW,
    input logic                      dataAck,
    input logic [`MIPS_XLEN-1:0]     debugPc,
    input logic                      debugWen,
    input logic [`MIPS_REG_BITS-1:0] debugWnum,
    input logic [`MIPS_XLEN-1:0]     debugWdata,
    input logic                      expValid,
    input logic [`MIPS_XLEN-1:0]     expPc,
    input logic [`MIPS_REG_BITS-1:0] expWnum,
    input logic [`MIPS_XLEN-1:0]     expWdata
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // Quiet outputs while reset is held and right after release
    resetQuiet: assert property (@(posedge clk) reset && $past(reset) |-> !debugWen && !dataCyc)
        else begin
            $error("[ERROR] %0t: debugWen or dataCyc high during reset", $time);
            failCount++;
        end

    releaseQuiet: assert property (@(posedge clk) $fell(reset) |-> !debugWen && !dataCyc)
        else begin
            $error("[ERROR] %0t: debugWen or dataCyc high after reset release", $time);
            failCount++;
        end

    bootFetch: assert property (@(posedge clk)
        $fell(reset) |=> instrCyc && instrAdr == `MIPS_BOOT_ADDR)
        else begin
            $error("[ERROR] %0t: first fetch not at boot address, got %h", $time, instrAdr);
            failCount++;
        end

    // Wishbone classic: request held until ack
    instrHold: assert property (@(posedge clk) disable iff (reset)
        instrStb && !instrAck |=> instrStb && $stable(instrAdr))
        else begin
            $error("[ERROR] %0t: instruction request changed before ack", $time);
            failCount++;
        end

    dataHold: assert property (@(posedge clk) disable iff (reset)
        dataStb && !dataAck |=> dataStb && $stable(dataAdr) && $stable(dataWe)
            && $stable(dataDatW))
        else begin
            $error("[ERROR] %0t: data request changed before ack", $time);
            failCount++;
        end

    retireOrder: assert property (@(posedge clk) disable iff (reset)
        debugWen |-> expValid && debugWnum == expWnum && debugWdata == expWdata)
        else begin
            $error("[ERROR] %0t: write r%0d = %h, expected r%0d = %h (valid %b)",
                $time, debugWnum, debugWdata, expWnum, expWdata, expValid);
            failCount++;
        end

    // Retiring instruction address
    retirePc: assert property (@(posedge clk) disable iff (reset)
        debugWen && expValid |-> debugPc == expPc)
        else begin
            $error("[ERROR] %0t: write r%0d from pc %h, expected pc %h",
                $time, debugWnum, debugPc, expPc);
            failCount++;
        end

endmodule

`default_nettype wire

//--- tests/mipsCoreTb.sv
`default_nettype none

`include "mipsCore_defs.svh"

module mipsCoreTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset;
    logic        instrCyc;
    logic        instrStb;
    logic [31:0] instrAdr;
    logic [31:0] instrDatR;
    logic        instrAck;
    logic        dataCyc;
    logic        dataStb;
    logic        dataWe;
    logic [31:0] dataAdr;
    logic [31:0] dataDatW;
    logic [31:0] dataDatR;
    logic        dataAck;
    logic [31:0] debugPc;
    logic        debugWen;
    logic [4:0]  debugWnum;
    logic [31:0] debugWdata;

    logic [31:0] rom [256];
    logic [31:0] ram [64];
    logic [31:0] expPcs [32];
    logic [4:0]  expRegs [32];
    logic [31:0] expVals [32];
    int          expCount;
    int          retired;
    int          cycles;
    int          instrWait;
    int          dataWait;
    integer      seed = 7115;

    logic        expValid;
    logic [31:0] expPc;
    logic [4:0]  expWnum;
    logic [31:0] expWdata;

    mipsCore dut0 (
        .clk(clk),
        .reset(reset),
        .instrCyc(instrCyc),
        .instrStb(instrStb),
        .instrAdr(instrAdr),
        .instrDatR(instrDatR),
        .instrAck(instrAck),
        .dataCyc(dataCyc),
        .dataStb(dataStb),
        .dataWe(dataWe),
        .dataAdr(dataAdr),
        .dataDatW(dataDatW),
        .dataDatR(dataDatR),
        .dataAck(dataAck),
        .debugPc(debugPc),
        .debugWen(debugWen),
        .debugWnum(debugWnum),
        .debugWdata(debugWdata)
    );

    bind mipsCore mipsCoreAssertions checks0 (
        .clk(clk),
        .reset(reset),
        .instrCyc(instrCyc),
        .instrStb(instrStb),
        .instrAdr(instrAdr),
        .instrAck(instrAck),
        .dataCyc(dataCyc),
        .dataStb(dataStb),
        .dataWe(dataWe),
        .dataAdr(dataAdr),
        .dataDatW(dataDatW),
        .dataAck(dataAck),
        .debugPc(debugPc),
        .debugWen(debugWen),
        .debugWnum(debugWnum),
        .debugWdata(debugWdata),
        .expValid(mipsCoreTb.expValid),
        .expPc(mipsCoreTb.expPc),
        .expWnum(mipsCoreTb.expWnum),
        .expWdata(mipsCoreTb.expWdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic int drawDelay();
        return $unsigned($random(seed)) % 4;
    endfunction

    // ROM word index of the writing instruction, then register and value
    task automatic expectWrite(input int index, input logic [4:0] regNum,
                               input logic [31:0] value);
        expPcs[expCount] = index * 4;
        expRegs[expCount] = regNum;
        expVals[expCount] = value;
        expCount++;
    endtask

    task automatic loadProgram();
        // Unknown opcode 0x3f runs as a NOP
        for (int i = 0; i < 256; i++) begin
            rom[i] = {6'h3f, 26'(i)};
        end
        rom[0] = iType(6'h09, 0, 1, 16'd6);
        rom[1] = iType(6'h09, 1, 2, 16'd9);
        rom[2] = rType(1, 2, 3, 6'h21);
        rom[3] = rType(3, 1, 4, 6'h23);
        rom[4] = rType(3, 2, 5, 6'h24);
        rom[5] = rType(5, 1, 6, 6'h25);
        rom[6] = rType(5, 4, 7, 6'h2a);
        rom[7] = iType(6'h09, 0, 8, 16'hfffd);
        rom[8] = rType(8, 7, 9, 6'h2a);
        rom[9] = iType(6'h0d, 6, 10, 16'ha500);
        rom[10] = iType(6'h0f, 0, 11, 16'h1234);
        rom[11] = rType(11, 10, 12, 6'h21);
        // Store, dependent load, immediate consumer
        rom[12] = iType(6'h09, 0, 13, 16'h0040);
        rom[13] = iType(6'h2b, 13, 12, 16'd4);
        rom[14] = iType(6'h23, 13, 14, 16'd4);
        rom[15] = rType(14, 1, 15, 6'h21);
        // Taken BEQ, skips index 18
        rom[16] = iType(6'h04, 15, 15, 16'd2);
        rom[17] = iType(6'h09, 0, 16, 16'h0011);
        rom[18] = iType(6'h09, 0, 17, 16'h0bad);
        rom[19] = iType(6'h09, 0, 18, 16'h0022);
        // BNE not taken
        rom[20] = iType(6'h05, 1, 1, 16'd5);
        rom[21] = iType(6'h09, 0, 19, 16'h0033);
        rom[22] = iType(6'h09, 0, 20, 16'h0044);
        rom[23] = jType(6'h02, 26'd26);
        rom[24] = iType(6'h09, 0, 21, 16'h0055);
        rom[25] = iType(6'h09, 0, 17, 16'h0bad);
        rom[26] = iType(6'h09, 0, 22, 16'h0066);
        rom[27] = iType(6'h09, 0, 23, 16'h007c);
        rom[28] = rType(23, 0, 0, 6'h08);
        rom[29] = iType(6'h09, 0, 24, 16'h0077);
        rom[30] = iType(6'h09, 0, 17, 16'h0bad);
        rom[31] = iType(6'h09, 0, 25, 16'h0088);
        // Park in a loop
        rom[32] = jType(6'h02, 26'd32);
        rom[33] = 32'h0000_0000;
    endtask

    task automatic buildExpectedTable();
        expCount = 0;
        expectWrite(0, 1, 32'd6);
        expectWrite(1, 2, 32'd15);
        expectWrite(2, 3, 32'd21);
        expectWrite(3, 4, 32'd15);
        expectWrite(4, 5, 32'd5);
        expectWrite(5, 6, 32'd7);
        expectWrite(6, 7, 32'd1);
        expectWrite(7, 8, 32'hffff_fffd);
        expectWrite(8, 9, 32'd1);
        expectWrite(9, 10, 32'h0000_a507);
        expectWrite(10, 11, 32'h1234_0000);
        expectWrite(11, 12, 32'h1234_a507);
        expectWrite(12, 13, 32'h0000_0040);
        expectWrite(14, 14, 32'h1234_a507);
        expectWrite(15, 15, 32'h1234_a50d);
        expectWrite(17, 16, 32'h0000_0011);
        expectWrite(19, 18, 32'h0000_0022);
        expectWrite(21, 19, 32'h0000_0033);
        expectWrite(22, 20, 32'h0000_0044);
        expectWrite(24, 21, 32'h0000_0055);
        expectWrite(26, 22, 32'h0000_0066);
        expectWrite(27, 23, 32'h0000_007c);
        expectWrite(29, 24, 32'h0000_0077);
        expectWrite(31, 25, 32'h0000_0088);
    endtask

    assign expValid = retired < expCount;
    assign expPc = expValid ? expPcs[retired] : 32'd0;
    assign expWnum = expValid ? expRegs[retired] : 5'd0;
    assign expWdata = expValid ? expVals[retired] : 32'd0;

    always @(posedge clk) begin
        if (reset) begin
            retired <= 0;
        end else if (debugWen) begin
            retired <= retired + 1;
        end
    end

    // Instruction ROM slave
    always @(posedge clk) begin
        if (reset) begin
            instrAck <= 1'b0;
            instrWait <= 0;
        end else if (instrAck) begin
            instrAck <= 1'b0;
        end else if (instrCyc && instrStb) begin
            if (instrWait == 0) begin
                instrAck <= 1'b1;
                instrDatR <= rom[instrAdr[9:2]];
                instrWait <= drawDelay();
            end else begin
                instrWait <= instrWait - 1;
            end
        end
    end

    // Data RAM slave
    always @(posedge clk) begin
        if (reset) begin
            dataAck <= 1'b0;
            dataWait <= 0;
        end else if (dataAck) begin
            dataAck <= 1'b0;
        end else if (dataCyc && dataStb) begin
            if (dataWait == 0) begin
                dataAck <= 1'b1;
                if (dataWe) begin
                    ram[dataAdr[7:2]] <= dataDatW;
                end else begin
                    dataDatR <= ram[dataAdr[7:2]];
                end
                dataWait <= drawDelay();
            end else begin
                dataWait <= dataWait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (dut0.checks0.failCount != 0) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Bound checker reported a failure");
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instrDatR = '0;
        instrAck = 1'b0;
        dataDatR = '0;
        dataAck = 1'b0;
        retired = 0;
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'hdead_0000 ^ (i * 4);
        end
        loadProgram();
        buildExpectedTable();

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (retired < expCount && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < expCount) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Timed out after %0d cycles with %0d of %0d writes retired",
                cycles, retired, expCount);
        end

        // Quiet period catches stray marker writes
        repeat (100) @(posedge clk);

        if (retired != expCount || dut0.checks0.failCount != 0) begin
            $display("[ERROR] %0t: retired %0d writes, expected %0d", $time, retired, expCount);
            $display("*** TEST FAILED ***");
            $fatal(1, "Retirement count mismatch");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/mipsCorePkg.sv
src/registerFile.sv
src/arithmeticLogicUnit.sv
src/instructionDecoder.sv
src/fetchUnit.sv
src/decodeStage.sv
src/memoryStage.sv
src/mipsCore.sv
tests/mipsCore_assertions.sv
tests/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  - include_dirs:
      - src
    files:
      - src/mipsCorePkg.sv
      - src/registerFile.sv
      - src/arithmeticLogicUnit.sv
      - src/instructionDecoder.sv
      - src/fetchUnit.sv
      - src/decodeStage.sv
      - src/memoryStage.sv
      - src/mipsCore.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/mipsCore_assertions.sv
      - tests/mipsCoreTb.sv
